// File: list.f
design/alu_pkg.sv
design/alu_cmd_if.sv
design/register_file.sv
design/alu_registers.sv
design/alu_csr.sv
design/alu_top.sv
bench/alu_checker.sv
bench/tb_top.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = tb_top
RTL_TOP    = alu_top
FILE_LIST  = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = STATUS: FAIL

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# A crashed simulation counts as a failure.
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed."; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_BITS   = 8;
    localparam int DRIVE_DELAY = 1;
    localparam int N_WRITE     = 24;
    localparam int N_ARITH     = 48;
    // Bus transactions issued by the stimulus below.
    localparam int N_TRANS     = 16 * 2 + N_WRITE * 6 + N_ARITH * 4 + 11;
    localparam int CYCLE_LIMIT = N_TRANS * 20 + 200;

    logic        clk;
    logic        arst_n;
    logic [3:0]  awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [2:0]  test_id;
    int          error_count, check_count, outstanding;
    int          cycle_count;
    logic [31:0] rng_state = 32'd13752;

    alu_top #(.DATA_BITS(DATA_BITS)) u_dut (.*);

    alu_checker #(.DATA_BITS(DATA_BITS)) u_check (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Ready is high three cycles out of four.
    function automatic logic ready_draw();
        logic [31:0] rnd;
        rnd = next_random();
        return rnd[1:0] != 2'b00;
    endfunction

    function automatic logic [31:0] command_word(input alu_pkg::alu_op_e op,
                                                 input logic [3:0] a, b, r);
        logic [31:0] noise;
        noise = next_random();
        return {noise[31:16], r, b, a, 2'b00, op}; // Upper bits only read back.
    endfunction

    // Called just after a rising edge, returns just after one.
    task automatic take_response(input logic read_channel);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            if (read_channel) begin
                rready = ready_draw();
            end else begin
                bready = ready_draw();
            end
            @(negedge clk);
            seen = read_channel ? (rvalid && rready) : (bvalid && bready);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        bready = 1'b0;
        rready = 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        take_response(1'b0);
    endtask

    task automatic axi_read(input logic [3:0] addr);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        arvalid = 1'b0;
        take_response(1'b1);
    endtask

    task automatic read_register(input logic [3:0] a);
        axi_write(alu_pkg::OFS_CMD, command_word(alu_pkg::REG_READ, a, 4'd0, 4'd0));
        axi_read(alu_pkg::OFS_RESULT);
    endtask

    task automatic finish_run(input logic timed_out);
        $display("Checks: %0d, errors: %0d, responses outstanding: %0d",
                 check_count, error_count, outstanding);
        if (timed_out || error_count != 0 || outstanding != 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    endtask

    initial begin
        logic [31:0]      rnd;
        logic [3:0]       a;
        alu_pkg::alu_op_e op;
        arst_n  = 1'b0;
        test_id = 3'd0;
        awaddr  = '0;
        wdata   = '0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY arst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;

        test_id = 3'd1;
        for (int i = 0; i < 16; i++) begin
            read_register(4'(i));
        end

        test_id = 3'd2;
        for (int i = 0; i < N_WRITE; i++) begin
            rnd = next_random();
            a   = rnd[7:4];
            axi_write(alu_pkg::OFS_WDATA, next_random());
            axi_write(alu_pkg::OFS_CMD, command_word(alu_pkg::REG_WRITE, a, 4'd0, 4'd0));
            read_register(a);
            axi_read(alu_pkg::OFS_WDATA);
            axi_read(alu_pkg::OFS_CMD);
        end

        test_id = 3'd3;
        for (int i = 0; i < N_ARITH; i++) begin
            rnd = next_random();
            op  = rnd[0] ? alu_pkg::SUB : alu_pkg::ADD;
            axi_write(alu_pkg::OFS_CMD, command_word(op, rnd[7:4], rnd[11:8], rnd[15:12]));
            axi_read(alu_pkg::OFS_STATUS);
            read_register(rnd[15:12]);
        end

        test_id = 3'd4;
        axi_write(alu_pkg::OFS_RESULT, next_random());
        axi_write(alu_pkg::OFS_STATUS, next_random());
        for (int addr = 13; addr < 16; addr++) begin
            axi_write(4'(addr), next_random());
            axi_read(4'(addr));
        end
        axi_read(alu_pkg::OFS_RESULT);
        axi_read(alu_pkg::OFS_STATUS);
        axi_read(alu_pkg::OFS_WDATA);
        finish_run(1'b0);
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
        finish_run(1'b1);
    end

endmodule

// File: bench/alu_checker.sv
module alu_checker #(
    parameter int DATA_BITS = 8
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [3:0]  awaddr,
    input  logic [3:0]  araddr,
    input  logic [31:0] wdata,
    input  logic [31:0] rdata,
    input  logic [1:0]  bresp,
    input  logic [1:0]  rresp,
    input  logic        awvalid, awready, wvalid, wready, bvalid, bready,
    input  logic        arvalid, arready, rvalid, rready,
    input  logic [2:0]  test_id,
    output int          error_count,
    output int          check_count,
    output int          outstanding
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [DATA_BITS-1:0] regs [16];
    logic [31:0]          cmd_m;
    logic [31:0]          wdata_m;
    logic [DATA_BITS-1:0] result_m;
    logic                 carry_m;
    logic [1:0]           b_expect [$];
    logic [33:0]          r_expect [$]; // {rresp, rdata}.
    logic                 b_held;
    logic                 r_held;
    logic [1:0]           b_last;
    logic [33:0]          r_last;
    int                   errors = 0;
    int                   checks = 0;
    int                   pending = 0;

    assign error_count = errors;
    assign check_count = checks;
    assign outstanding = pending;

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd1:    return "reset_read";
            3'd2:    return "write_read";
            3'd3:    return "add_sub";
            3'd4:    return "bad_access";
            default: return "setup";
        endcase
    endfunction

    task automatic compare(input string what, input logic [35:0] expected,
                           input logic [35:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s %s: expected %h actual %h",
                     test_label(test_id), what, expected, actual);
        end
    endtask

    // Register effect of one accepted command word.
    task automatic run_command(input logic [31:0] word);
        logic [3:0]         a;
        logic [3:0]         b;
        logic [3:0]         r;
        logic [DATA_BITS:0] sum;
        a = word[7:4];
        b = word[11:8];
        r = word[15:12];
        case (alu_pkg::alu_op_e'(word[1:0]))
            alu_pkg::REG_READ:  result_m = regs[a];
            alu_pkg::REG_WRITE: regs[a] = wdata_m[DATA_BITS-1:0];
            alu_pkg::ADD: begin
                sum     = {1'b0, regs[a]} + {1'b0, regs[b]};
                regs[r] = sum[DATA_BITS-1:0];
                carry_m = sum[DATA_BITS];
            end
            default: begin
                sum     = {1'b0, regs[a]} + {1'b0, ~regs[b]} + {{DATA_BITS{1'b0}}, 1'b1};
                regs[r] = sum[DATA_BITS-1:0];
                carry_m = sum[DATA_BITS];
            end
        endcase
    endtask

    function automatic logic [33:0] read_value(input logic [3:0] addr);
        case (addr)
            alu_pkg::OFS_CMD:    return {alu_pkg::RESP_OKAY, cmd_m};
            alu_pkg::OFS_WDATA:  return {alu_pkg::RESP_OKAY, wdata_m};
            alu_pkg::OFS_RESULT: return {alu_pkg::RESP_OKAY, {(32 - DATA_BITS){1'b0}}, result_m};
            alu_pkg::OFS_STATUS: return {alu_pkg::RESP_OKAY, 30'd0, carry_m, 1'b0};
            default:             return {alu_pkg::RESP_SLVERR, 32'd0};
        endcase
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] = '0;
            end
            cmd_m    = '0;
            wdata_m  = '0;
            result_m = '0;
            carry_m  = 1'b0;
            b_held   = 1'b0;
            r_held   = 1'b0;
            b_expect.delete();
            r_expect.delete();
        end else begin
            // A stalled response must hold its value.
            if (b_held) begin
                compare("held write response", 36'({1'b1, b_last}), 36'({bvalid, bresp}));
            end
            if (r_held) begin
                compare("held read data", {1'b0, 1'b1, r_last}, {1'b0, rvalid, rresp, rdata});
            end
            b_held = bvalid && !bready;
            b_last = bresp;
            r_held = rvalid && !rready;
            r_last = {rresp, rdata};

            if (bvalid && bready) begin
                if (b_expect.size() == 0) begin
                    errors++;
                    $display("Error: a write response arrived with no write outstanding.");
                end else begin
                    compare("write response", 36'(b_expect.pop_front()), 36'(bresp));
                end
            end
            if (rvalid && rready) begin
                if (r_expect.size() == 0) begin
                    errors++;
                    $display("Error: read data arrived with no read outstanding.");
                end else begin
                    compare("read data", 36'(r_expect.pop_front()), 36'({rresp, rdata}));
                end
            end

            if (awvalid && awready && wvalid && wready) begin
                case (awaddr)
                    alu_pkg::OFS_CMD: begin
                        cmd_m = wdata;
                        run_command(wdata);
                        b_expect.push_back(alu_pkg::RESP_OKAY);
                    end
                    alu_pkg::OFS_WDATA: begin
                        wdata_m = wdata;
                        b_expect.push_back(alu_pkg::RESP_OKAY);
                    end
                    default: b_expect.push_back(alu_pkg::RESP_SLVERR);
                endcase
            end
            if (arvalid && arready) begin
                r_expect.push_back(read_value(araddr));
            end
            pending = b_expect.size() + r_expect.size();
        end
    end

endmodule

// File: design/alu_top.sv
module alu_top #(
    parameter int DATA_BITS = 8
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic [alu_pkg::REG_ADDR_BITS-1:0] rd0_addr;
    logic                              rd0_enable;
    logic [DATA_BITS-1:0]              rd0_data;
    logic [alu_pkg::REG_ADDR_BITS-1:0] rd1_addr;
    logic                              rd1_enable;
    logic [DATA_BITS-1:0]              rd1_data;
    logic [alu_pkg::REG_ADDR_BITS-1:0] wr_addr;
    logic                              wr_enable;
    logic [DATA_BITS-1:0]              wr_data;

    alu_cmd_if #(.DATA_BITS(DATA_BITS)) u_cmd_if ();

    alu_csr #(.DATA_BITS(DATA_BITS)) u_csr (
        .clk     (clk),     .arst_n  (arst_n),
        .awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wvalid  (wvalid),  .wready  (wready),
        .bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
        .araddr  (araddr),  .arvalid (arvalid), .arready (arready),
        .rdata   (rdata),   .rresp   (rresp),   .rvalid  (rvalid),
        .rready  (rready),  .cmd     (u_cmd_if.csr)
    );

    alu_registers #(.DATA_BITS(DATA_BITS)) u_seq (
        .clk        (clk),        .arst_n     (arst_n),     .cmd      (u_cmd_if.seq),
        .rd0_addr   (rd0_addr),   .rd0_enable (rd0_enable), .rd0_data (rd0_data),
        .rd1_addr   (rd1_addr),   .rd1_enable (rd1_enable), .rd1_data (rd1_data),
        .wr_addr    (wr_addr),    .wr_enable  (wr_enable),  .wr_data  (wr_data)
    );

    register_file #(.DATA_BITS(DATA_BITS)) u_regs (
        .clk        (clk),        .arst_n     (arst_n),
        .rd0_addr   (rd0_addr),   .rd0_enable (rd0_enable), .rd0_data (rd0_data),
        .rd1_addr   (rd1_addr),   .rd1_enable (rd1_enable), .rd1_data (rd1_data),
        .wr_addr    (wr_addr),    .wr_enable  (wr_enable),  .wr_data  (wr_data)
    );

endmodule

// File: design/alu_csr.sv
module alu_csr #(
    parameter int DATA_BITS = 8
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    alu_cmd_if.csr      cmd
);

    logic [31:0]          cmd_q;
    logic [31:0]          wdata_q;
    logic [DATA_BITS-1:0] result_q;
    logic                 carry_q;
    logic                 busy_q;
    logic                 start_q;
    logic                 wr_hs;
    logic                 rd_hs;
    logic                 rvalid_next;

    // Address and data are taken together, never while a response is owed.
    assign wr_hs   = awvalid && wvalid && !bvalid && !busy_q;
    assign awready = wr_hs;
    assign wready  = wr_hs;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_q    <= '0;
            wdata_q  <= '0;
            result_q <= '0;
            carry_q  <= 1'b0;
            busy_q   <= 1'b0;
            start_q  <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= alu_pkg::RESP_OKAY;
        end else begin
            start_q <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_hs) begin
                case (awaddr)
                    alu_pkg::OFS_CMD: begin
                        cmd_q   <= wdata;
                        start_q <= 1'b1;
                        busy_q  <= 1'b1; // Response waits for done.
                        bresp   <= alu_pkg::RESP_OKAY;
                    end
                    alu_pkg::OFS_WDATA: begin
                        wdata_q <= wdata;
                        bvalid  <= 1'b1;
                        bresp   <= alu_pkg::RESP_OKAY;
                    end
                    default: begin
                        bvalid <= 1'b1;
                        bresp  <= alu_pkg::RESP_SLVERR;
                    end
                endcase
            end
            if (cmd.done) begin
                busy_q <= 1'b0;
                bvalid <= 1'b1;
                if (cmd.op == alu_pkg::REG_READ) begin
                    result_q <= cmd.data_out;
                end
                if (cmd.op inside {alu_pkg::ADD, alu_pkg::SUB}) begin
                    carry_q <= cmd.carry;
                end
            end
        end
    end

    assign rd_hs       = arvalid && arready;
    assign rvalid_next = rd_hs || (rvalid && !rready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= alu_pkg::RESP_OKAY;
        end else begin
            arready <= !rvalid_next;
            rvalid  <= rvalid_next;
            if (rd_hs) begin
                rresp <= alu_pkg::RESP_OKAY;
                case (araddr)
                    alu_pkg::OFS_CMD:    rdata <= cmd_q;
                    alu_pkg::OFS_WDATA:  rdata <= wdata_q;
                    alu_pkg::OFS_RESULT: rdata <= {{(32 - DATA_BITS){1'b0}}, result_q};
                    alu_pkg::OFS_STATUS: rdata <= {30'd0, carry_q, busy_q};
                    default: begin
                        rdata <= '0;
                        rresp <= alu_pkg::RESP_SLVERR;
                    end
                endcase
            end
        end
    end

    assign cmd.start   = start_q;
    assign cmd.op      = alu_pkg::alu_op_e'(cmd_q[1:0]);
    assign cmd.addr_a  = cmd_q[7:4];
    assign cmd.addr_b  = cmd_q[11:8];
    assign cmd.addr_r  = cmd_q[15:12];
    assign cmd.data_in = wdata_q[DATA_BITS-1:0];

    a_b_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

    a_r_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

// File: design/alu_registers.sv
module alu_registers #(
    parameter int DATA_BITS = 8
) (
    input  logic                              clk,
    input  logic                              arst_n,
    alu_cmd_if.seq                            cmd,
    output logic [alu_pkg::REG_ADDR_BITS-1:0] rd0_addr,
    output logic                              rd0_enable,
    input  logic [DATA_BITS-1:0]              rd0_data,
    output logic [alu_pkg::REG_ADDR_BITS-1:0] rd1_addr,
    output logic                              rd1_enable,
    input  logic [DATA_BITS-1:0]              rd1_data,
    output logic [alu_pkg::REG_ADDR_BITS-1:0] wr_addr,
    output logic                              wr_enable,
    output logic [DATA_BITS-1:0]              wr_data
);

    logic                 rd_a_q;   // Cycle 1, read of A.
    logic                 rd_b_q;   // Cycle 1, read of B.
    logic                 load_q;   // Cycle 1, REG_WRITE.
    logic                 wb_q;     // Cycle 2, ADD/SUB write back.
    logic                 done_q;
    logic                 subtract;
    logic [DATA_BITS-1:0] operand_b;
    logic [DATA_BITS:0]   total;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_a_q <= 1'b0;
            rd_b_q <= 1'b0;
            load_q <= 1'b0;
            wb_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            rd_a_q <= cmd.start && (cmd.op != alu_pkg::REG_WRITE);
            rd_b_q <= cmd.start && (cmd.op inside {alu_pkg::ADD, alu_pkg::SUB});
            load_q <= cmd.start && (cmd.op == alu_pkg::REG_WRITE);
            wb_q   <= rd_b_q;
            done_q <= rd_a_q || load_q; // Every op sets exactly one of these.
        end
    end

    assign rd0_enable = rd_a_q;
    assign rd0_addr   = cmd.addr_a;
    assign rd1_enable = rd_b_q;
    assign rd1_addr   = cmd.addr_b;

    // A - B is A + ~B + 1.
    assign subtract  = (cmd.op == alu_pkg::SUB);
    assign operand_b = subtract ? ~rd1_data : rd1_data;
    assign total     = {1'b0, rd0_data} + {1'b0, operand_b} + {{DATA_BITS{1'b0}}, subtract};

    // Write-back source is data_in for REG_WRITE, else the adder.
    assign wr_enable = load_q || wb_q;
    assign wr_addr   = load_q ? cmd.addr_a : cmd.addr_r;
    assign wr_data   = load_q ? cmd.data_in : total[DATA_BITS-1:0];

    assign cmd.done     = done_q;
    assign cmd.data_out = rd0_data;
    assign cmd.carry    = total[DATA_BITS];

    a_no_overlap: assert property (
        @(posedge clk) disable iff (!arst_n)
        cmd.start |-> !(rd_a_q || load_q || done_q)
    );

    a_done_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        cmd.start |-> ##2 cmd.done
    );

endmodule

// File: design/register_file.sv
module register_file #(
    parameter int DATA_BITS = 8
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [alu_pkg::REG_ADDR_BITS-1:0] rd0_addr,
    input  logic                              rd0_enable,
    output logic [DATA_BITS-1:0]              rd0_data,
    input  logic [alu_pkg::REG_ADDR_BITS-1:0] rd1_addr,
    input  logic                              rd1_enable,
    output logic [DATA_BITS-1:0]              rd1_data,
    input  logic [alu_pkg::REG_ADDR_BITS-1:0] wr_addr,
    input  logic                              wr_enable,
    input  logic [DATA_BITS-1:0]              wr_data
);

    localparam int DEPTH = 2 ** alu_pkg::REG_ADDR_BITS;

    logic [DATA_BITS-1:0] regs [DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_enable) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Read data holds its value while the port is idle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd0_data <= '0;
            rd1_data <= '0;
        end else begin
            if (rd0_enable) begin
                rd0_data <= regs[rd0_addr];
            end
            if (rd1_enable) begin
                rd1_data <= regs[rd1_addr];
            end
        end
    end

    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_enable |-> !$isunknown(wr_addr)
    );

endmodule

// File: design/alu_cmd_if.sv
interface alu_cmd_if #(
    parameter int DATA_BITS = 8
);

    logic                              start;   // One-cycle pulse.
    alu_pkg::alu_op_e                  op;
    logic [alu_pkg::REG_ADDR_BITS-1:0] addr_a;
    logic [alu_pkg::REG_ADDR_BITS-1:0] addr_b;
    logic [alu_pkg::REG_ADDR_BITS-1:0] addr_r;
    logic [DATA_BITS-1:0]              data_in;
    logic                              done;    // One-cycle pulse.
    logic [DATA_BITS-1:0]              data_out;
    logic                              carry;

    // Operands hold from start until done.
    modport csr (
        output start, op, addr_a, addr_b, addr_r, data_in,
        input  done, data_out, carry
    );

    modport seq (
        input  start, op, addr_a, addr_b, addr_r, data_in,
        output done, data_out, carry
    );

endinterface

// File: design/alu_pkg.sv
package alu_pkg;

    // Command word layout, as written to OFS_CMD.
    //   bits  1..0   op
    //   bits  7..4   addr_a
    //   bits 11..8   addr_b
    //   bits 15..12  addr_r
    // The remaining bits are stored and read back but have no effect.

    typedef enum logic [1:0] {
        REG_READ  = 2'b00, // Result = rA.
        REG_WRITE = 2'b01, // rA = WDATA.
        ADD       = 2'b10, // rR = rA + rB.
        SUB       = 2'b11  // rR = rA - rB.
    } alu_op_e;

    parameter int REG_ADDR_BITS = 4;

    // Byte offsets of the host register map.
    parameter logic [3:0] OFS_CMD    = 4'h0;
    parameter logic [3:0] OFS_WDATA  = 4'h4;
    parameter logic [3:0] OFS_RESULT = 4'h8;
    parameter logic [3:0] OFS_STATUS = 4'hC;

    // AXI response codes.
    parameter logic [1:0] RESP_OKAY   = 2'b00;
    parameter logic [1:0] RESP_SLVERR = 2'b10;

endpackage
